// File: verilog/fme7_pkg.sv
// FME-7 widths, address decode constants, command numbers, mirroring codes and parameter union
`default_nettype none

package fme7_pkg;

	// bus widths
	localparam int CPU_ADDR_W    = 16;
	localparam int PPU_ADDR_W    = 14;
	localparam int OUT_ADDR_W    = 22;
	localparam int TAG_W         = 4;  // prefix that picks the memory type
	localparam int PRG_OFS_W     = 13; // 8 kB PRG windows
	localparam int CHR_OFS_W     = 10; // 1 kB CHR banks

	// bank registers
	localparam int CHR_BANK_W    = 8;
	localparam int PRG_BANK_W    = 5;
	localparam int NUM_CHR_BANKS = 8;
	localparam int NUM_PRG_WIN   = 4; // $6000, $8000, $A000, $C000

	// address prefixes in the mapped space
	localparam logic [TAG_W-1:0] WRAM_TAG = 4'b1111;
	localparam logic [TAG_W-1:0] CHR_TAG  = 4'b1000;

	// CPU decode, prg_ain[14:13] inside $8000-$FFFF
	localparam logic [1:0] REGION_CMD   = 2'b00; // $8000-$9FFF
	localparam logic [1:0] REGION_PARAM = 2'b01; // $A000-$BFFF

	// CPU decode, prg_ain[15:13]
	localparam logic [2:0] WIN_WRAM  = 3'b011; // $6000, lowest mapped window
	localparam logic [2:0] WIN_FIXED = 3'b111; // $E000, hardwired to last bank

	// command numbers, 0 to 7 pick CHR banks
	localparam logic [3:0] CMD_PRG_BASE = 4'd8;
	localparam logic [3:0] CMD_MIRROR   = 4'd12;
	localparam logic [3:0] CMD_IRQ_CTRL = 4'd13;
	localparam logic [3:0] CMD_IRQ_LO   = 4'd14;
	localparam logic [3:0] CMD_IRQ_HI   = 4'd15;

	// nametable arrangement, as written with command 12
	typedef enum logic [1:0] {
		MIR_VERT   = 2'b00,
		MIR_HORZ   = 2'b01,
		MIR_ONE_LO = 2'b10,
		MIR_ONE_HI = 2'b11
	} mirror_t;

	// command 8 layout
	typedef struct packed {
		logic                  ram_enable;
		logic                  ram_select; // 1 maps WRAM at $6000
		logic                  spare;
		logic [PRG_BANK_W-1:0] bank;
	} prg_param_s;

	// parameter byte, plain bank number or command 8 fields
	typedef union packed {
		logic [7:0] raw;
		prg_param_s fields;
	} prg_param_u;

endpackage

`default_nettype wire

// File: verilog/fme7_bank_if.sv
// FME-7 bank and mapping state interface, command registers to address mappers
`timescale 1ns/1ps
`default_nettype none

interface fme7_bank_if
	import fme7_pkg::*;
();

	logic [NUM_CHR_BANKS-1:0][CHR_BANK_W-1:0] chr_bank; // one per 1 kB of pattern space
	logic [NUM_PRG_WIN-1:0][PRG_BANK_W-1:0]   prg_bank; // $6000 window first
	logic                                     ram_enable;
	logic                                     ram_select;
	mirror_t                                  mirror;

	modport regs (
		output chr_bank, prg_bank, ram_enable, ram_select, mirror
	);

	modport prg (
		input prg_bank, ram_enable, ram_select
	);

	modport chr (
		input chr_bank, mirror
	);

endinterface

`default_nettype wire

// File: verilog/fme7_irq_if.sv
// FME-7 IRQ control interface, command registers to IRQ counter
`timescale 1ns/1ps
`default_nettype none

interface fme7_irq_if
	import fme7_pkg::*;
();

	logic count_en;  // counter decrements
	logic irq_en;    // irq may assert
	logic load_lo;   // one cycle strobes
	logic load_hi;
	logic [7:0] load_data;

	modport regs (
		output count_en, irq_en, load_lo, load_hi, load_data
	);

	modport counter (
		input count_en, irq_en, load_lo, load_hi, load_data
	);

endinterface

`default_nettype wire

// File: verilog/fme7_cmd_regs.sv
// FME-7 command and parameter registers, CPU write decode
`timescale 1ns/1ps
`default_nettype none

module fme7_cmd_regs
	import fme7_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  ce,
	input  logic [CPU_ADDR_W-1:0] prg_ain,
	input  logic                  prg_write,
	input  logic [7:0]            prg_din,
	fme7_bank_if.regs             banks,
	fme7_irq_if.regs              irq_ctl
);

	logic [3:0] cmd;       // latched command number
	logic       cpu_wr;    // accepted write in $8000-$FFFF
	logic       cmd_wr;
	logic       param_wr;
	prg_param_u param;

	assign cpu_wr   = ce && prg_write && prg_ain[15];
	assign cmd_wr   = cpu_wr && (prg_ain[14:13] == REGION_CMD);
	assign param_wr = cpu_wr && (prg_ain[14:13] == REGION_PARAM);
	assign param    = prg_din;

	// counter loads go straight to the counter in the same cycle
	assign irq_ctl.load_lo   = param_wr && (cmd == CMD_IRQ_LO);
	assign irq_ctl.load_hi   = param_wr && (cmd == CMD_IRQ_HI);
	assign irq_ctl.load_data = prg_din;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cmd              <= '0;
			banks.chr_bank   <= '0;
			banks.prg_bank   <= '0;
			banks.ram_enable <= 1'b0;
			banks.ram_select <= 1'b0;
			banks.mirror     <= MIR_VERT;
			irq_ctl.count_en <= 1'b0;
			irq_ctl.irq_en   <= 1'b0;
		end else if (cmd_wr) begin
			cmd <= prg_din[3:0];
		end else if (param_wr) begin
			if (!cmd[3]) begin
				banks.chr_bank[cmd[2:0]] <= prg_din; // commands 0 to 7
			end else begin
				case (cmd)
					CMD_PRG_BASE: begin
						banks.prg_bank[0] <= param.fields.bank;
						banks.ram_enable  <= param.fields.ram_enable;
						banks.ram_select  <= param.fields.ram_select;
					end
					CMD_MIRROR: begin
						banks.mirror <= mirror_t'(prg_din[1:0]);
					end
					CMD_IRQ_CTRL: begin
						irq_ctl.count_en <= prg_din[7];
						irq_ctl.irq_en   <= prg_din[0]; // clear acknowledges a pending irq
					end
					CMD_IRQ_LO, CMD_IRQ_HI: begin
						// strobes only, nothing held here
					end
					default: begin
						banks.prg_bank[cmd[1:0]] <= param.raw[PRG_BANK_W-1:0]; // 9 to 11
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/fme7_prg_map.sv
// FME-7 CPU address to PRG ROM or WRAM address, with access permission
`timescale 1ns/1ps
`default_nettype none

module fme7_prg_map
	import fme7_pkg::*;
(
	input  logic [CPU_ADDR_W-1:0] prg_ain,
	input  logic                  prg_write,
	fme7_bank_if.prg              banks,
	output logic [OUT_ADDR_W-1:0] prg_aout,
	output logic                  prg_allow
);

	logic [2:0]            win;    // 8 kB window number
	logic [PRG_BANK_W-1:0] bank;
	logic                  mapped; // $6000 and up
	logic                  ram_cs;
	logic [TAG_W-1:0]      tag;

	assign win = prg_ain[15:13];

	always_comb begin
		case (win)
			WIN_WRAM: bank = banks.prg_bank[0];
			3'b100:   bank = banks.prg_bank[1];
			3'b101:   bank = banks.prg_bank[2];
			3'b110:   bank = banks.prg_bank[3];
			default:  bank = '1; // $E000 and unmapped space
		endcase
	end

	assign mapped = (win >= WIN_WRAM);
	assign ram_cs = (win == WIN_WRAM) && banks.ram_select;
	assign tag    = ram_cs ? WRAM_TAG : '0;

	assign prg_aout  = {tag, bank, prg_ain[PRG_OFS_W-1:0]};
	assign prg_allow = mapped && (ram_cs ? banks.ram_enable : !prg_write); // ROM is read only

endmodule

`default_nettype wire

// File: verilog/fme7_chr_map.sv
// FME-7 PPU address to CHR address, VRAM enable and nametable A10
`timescale 1ns/1ps
`default_nettype none

module fme7_chr_map
	import fme7_pkg::*;
(
	input  logic [PPU_ADDR_W-1:0] chr_ain,
	fme7_bank_if.chr              banks,
	output logic [OUT_ADDR_W-1:0] chr_aout,
	output logic                  vram_a10,
	output logic                  vram_ce
);

	logic [2:0]            slot; // 1 kB slot in pattern space
	logic [CHR_BANK_W-1:0] bank;

	assign slot = chr_ain[CHR_OFS_W +: 3];
	assign bank = banks.chr_bank[slot];

	assign chr_aout = {CHR_TAG, bank, chr_ain[CHR_OFS_W-1:0]};
	assign vram_ce  = chr_ain[13]; // nametables live in console VRAM

	always_comb begin
		case (banks.mirror)
			MIR_VERT: vram_a10 = chr_ain[10];
			MIR_HORZ: vram_a10 = chr_ain[11];
			default:  vram_a10 = banks.mirror[0]; // one-screen, lower or upper
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/fme7_irq_counter.sv
// FME-7 16-bit CPU cycle down-counter and IRQ flag
`timescale 1ns/1ps
`default_nettype none

module fme7_irq_counter
	import fme7_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        ce,
	fme7_irq_if.counter irq_ctl,
	output logic        irq
);

	logic [15:0] counter;
	logic [16:0] next_count; // bit 16 is the borrow
	logic        loading;
	logic        underflow;

	assign next_count = {1'b0, counter} - {16'd0, irq_ctl.count_en};
	assign loading    = irq_ctl.load_lo || irq_ctl.load_hi;
	assign underflow  = next_count[16] && !loading; // 0 to FFFF step

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			counter <= '0;
			irq     <= 1'b0;
		end else if (ce) begin
			if (loading) begin
				// byte load wins over the decrement
				if (irq_ctl.load_lo) begin
					counter[7:0] <= irq_ctl.load_data;
				end
				if (irq_ctl.load_hi) begin
					counter[15:8] <= irq_ctl.load_data;
				end
			end else begin
				counter <= next_count[15:0];
			end

			if (!irq_ctl.irq_en) begin
				irq <= 1'b0; // acknowledge
			end else if (underflow) begin
				irq <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/fme7_top.sv
// FME-7 mapper top level, interface instances and submodule wiring
`timescale 1ns/1ps
`default_nettype none

module fme7_top (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        ce,        // one CPU cycle
	input  logic [15:0] prg_ain,
	input  logic        prg_write,
	input  logic [7:0]  prg_din,
	input  logic [13:0] chr_ain,
	output logic [21:0] prg_aout,
	output logic        prg_allow,
	output logic [21:0] chr_aout,
	output logic        vram_a10,
	output logic        vram_ce,
	output logic        irq
);

	fme7_bank_if banks ();
	fme7_irq_if  irq_ctl ();

	fme7_cmd_regs u_cmd_regs (
		.clk       (clk),
		.arst_n    (arst_n),
		.ce        (ce),
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.prg_din   (prg_din),
		.banks     (banks),
		.irq_ctl   (irq_ctl)
	);

	fme7_prg_map u_prg_map (
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.banks     (banks),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow)
	);

	fme7_chr_map u_chr_map (
		.chr_ain  (chr_ain),
		.banks    (banks),
		.chr_aout (chr_aout),
		.vram_a10 (vram_a10),
		.vram_ce  (vram_ce)
	);

	fme7_irq_counter u_irq_counter (
		.clk     (clk),
		.arst_n  (arst_n),
		.ce      (ce),
		.irq_ctl (irq_ctl),
		.irq     (irq)
	);

endmodule

`default_nettype wire

// File: tb/tb_fme7.sv
// FME-7 mapper testbench with reference rules, directed tests, watchdog and summary
`timescale 1ns/1ps
`default_nettype none

module tb_fme7
	import fme7_pkg::*;
();

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 2;
	localparam int WRITE_CYCLES = 4;  // command write then parameter write
	localparam int NUM_WRITES   = 30; // register writes over all tests, rounded up
	localparam int PROBE_CYCLES = 3;
	localparam int NUM_PROBES   = 70;
	localparam int IRQ_MAX_N    = 18;
	localparam int TIMEOUT_NS   = 2 * CLK_PERIOD * (RESET_CYCLES + NUM_WRITES * WRITE_CYCLES
		+ NUM_PROBES * PROBE_CYCLES + IRQ_MAX_N + 4);

	logic        clk;
	logic        arst_n;
	logic        ce;
	logic [15:0] prg_ain;
	logic        prg_write;
	logic [7:0]  prg_din;
	logic [13:0] chr_ain;
	logic [21:0] prg_aout;
	logic        prg_allow;
	logic [21:0] chr_aout;
	logic        vram_a10;
	logic        vram_ce;
	logic        irq;

	int errors = 0;
	int checks = 0;

	// expected mapping state, kept from the register rules
	logic [7:0] chr_model [8];
	logic [4:0] prg_model [4];
	logic       ram_en_model;
	logic       ram_sel_model;
	logic [1:0] mir_model;

	fme7_top UUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.ce        (ce),
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.prg_din   (prg_din),
		.chr_ain   (chr_ain),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow),
		.chr_aout  (chr_aout),
		.vram_a10  (vram_a10),
		.vram_ce   (vram_ce),
		.irq       (irq)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		assert (got === exp) else begin
			$display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	function automatic logic [21:0] exp_chr_aout(input logic [13:0] a);
		return {CHR_TAG, chr_model[a[12:10]], a[9:0]};
	endfunction

	function automatic logic exp_a10(input logic [13:0] a);
		case (mir_model)
			2'd0:    return a[10]; // vertical
			2'd1:    return a[11]; // horizontal
			2'd2:    return 1'b0;
			default: return 1'b1;
		endcase
	endfunction

	function automatic logic [21:0] exp_prg_aout(input logic [15:0] a);
		logic [4:0] bank;
		logic [3:0] tag;
		tag = 4'h0;
		case (a[15:13])
			3'd3: begin
				bank = prg_model[0];
				if (ram_sel_model) tag = WRAM_TAG;
			end
			3'd4:    bank = prg_model[1];
			3'd5:    bank = prg_model[2];
			3'd6:    bank = prg_model[3];
			default: bank = 5'h1F; // $E000 fixed to last bank
		endcase
		return {tag, bank, a[12:0]};
	endfunction

	function automatic logic exp_prg_allow(input logic [15:0] a, input logic wr);
		if (a < 16'h6000) return 1'b0;
		if (a[15:13] == 3'd3 && ram_sel_model) return ram_en_model;
		return !wr;
	endfunction

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk);
		prg_ain   <= addr;
		prg_din   <= data;
		prg_write <= 1'b1;
		@(posedge clk); // accepting edge
		prg_write <= 1'b0;
	endtask

	// register write plus the matching update of the expected state
	task automatic apply_param(input logic [3:0] cmd, input logic [7:0] value);
		cpu_write(16'h8000, {4'h0, cmd});
		cpu_write(16'hA000, value);
		if (cmd < 4'd8) begin
			chr_model[cmd[2:0]] = value;
		end else if (cmd == 4'd8) begin
			prg_model[0]  = value[4:0];
			ram_en_model  = value[7];
			ram_sel_model = value[6];
		end else if (cmd <= 4'd11) begin
			prg_model[2'(cmd - 4'd8)] = value[4:0];
		end else if (cmd == 4'd12) begin
			mir_model = value[1:0];
		end
	endtask

	task automatic probe_chr(input logic [13:0] a);
		@(posedge clk);
		chr_ain <= a;
		@(negedge clk);
		check_val("chr_aout", 32'(exp_chr_aout(a)), 32'(chr_aout));
		check_val("vram_ce", 32'(a[13]), 32'(vram_ce));
		check_val("vram_a10", 32'(exp_a10(a)), 32'(vram_a10));
	endtask

	task automatic probe_prg(input logic [15:0] a, input logic wr);
		@(posedge clk);
		prg_ain   <= a;
		prg_write <= wr;
		ce        <= !wr; // write probe must not land in a register
		@(negedge clk);
		if (a >= 16'h6000) check_val("prg_aout", 32'(exp_prg_aout(a)), 32'(prg_aout));
		check_val("prg_allow", 32'(exp_prg_allow(a, wr)), 32'(prg_allow));
		@(posedge clk);
		prg_write <= 1'b0;
		ce        <= 1'b1;
	endtask

	task automatic test_reset();
		check_val("irq", 32'(1'b0), 32'(irq));
		probe_chr(14'h0000);
		probe_chr(14'h0755);
		probe_chr(14'h1FFF);
		probe_chr(14'h2C12);
		probe_prg(16'hE123, 1'b0);
	endtask

	task automatic test_chr();
		logic [9:0] ofs;
		for (int i = 0; i < 8; i++) apply_param(4'(i), 8'($urandom));
		for (int s = 0; s < 8; s++) begin
			ofs = 10'($urandom);
			probe_chr({1'b0, 3'(s), ofs});
			probe_chr({1'b1, 3'(s), ofs}); // nametable side
		end
	endtask

	task automatic test_prg();
		logic [4:0] bank;
		for (int i = 9; i <= 11; i++) apply_param(4'(i), 8'($urandom));
		probe_prg(16'h8000 | 16'($urandom_range(16'h1FFF, 0)), 1'b0);
		probe_prg(16'hA000 | 16'($urandom_range(16'h1FFF, 0)), 1'b0);
		probe_prg(16'hC000 | 16'($urandom_range(16'h1FFF, 0)), 1'b0);
		probe_prg(16'h8001, 1'b1);
		probe_prg(16'hA002, 1'b1);
		probe_prg(16'hC003, 1'b1);
		bank = 5'($urandom);
		apply_param(CMD_PRG_BASE, {3'b000, bank}); // ROM at $6000
		probe_prg(16'h6ABC, 1'b0);
		probe_prg(16'h6ABC, 1'b1);
		apply_param(CMD_PRG_BASE, {3'b110, bank}); // WRAM enabled
		probe_prg(16'h7F00, 1'b0);
		probe_prg(16'h7F00, 1'b1);
		apply_param(CMD_PRG_BASE, {3'b010, bank}); // WRAM selected but disabled
		probe_prg(16'h6001, 1'b0);
		probe_prg(16'h6001, 1'b1);
		probe_prg(16'h0000, 1'b0);
		probe_prg(16'h4020, 1'b0);
		probe_prg(16'h5FFF, 1'b1);
	endtask

	task automatic test_mirror();
		for (int m = 0; m < 4; m++) begin
			apply_param(CMD_MIRROR, 8'(m));
			probe_chr(14'h2005);
			probe_chr(14'h2405);
			probe_chr(14'h2805);
			probe_chr(14'h2C05);
		end
	endtask

	task automatic test_irq();
		logic [15:0] n;
		n = 16'($urandom_range(IRQ_MAX_N, 2));
		apply_param(CMD_IRQ_LO, n[7:0]);
		apply_param(CMD_IRQ_HI, n[15:8]);
		apply_param(CMD_IRQ_CTRL, 8'h81); // count and irq enable
		for (int i = 1; i <= int'(n); i++) begin
			@(posedge clk);
			@(negedge clk);
			check_val("irq", 32'(1'b0), 32'(irq));
		end
		@(posedge clk); // underflow edge
		@(negedge clk);
		check_val("irq", 32'(1'b1), 32'(irq));
		apply_param(CMD_IRQ_CTRL, 8'h00);
		@(posedge clk);
		@(negedge clk);
		check_val("irq", 32'(1'b0), 32'(irq));
	endtask

	task automatic test_ignored();
		cpu_write(16'h8000, 8'h00); // point the command at CHR bank 0
		cpu_write(16'hC000, 8'($urandom));
		cpu_write(16'hD555, 8'($urandom));
		cpu_write(16'hE000, 8'($urandom));
		cpu_write(16'hFFFF, 8'($urandom));
		for (int s = 0; s < 8; s++) probe_chr({1'b0, 3'(s), 10'h2A5});
		probe_chr(14'h2400);
		probe_prg(16'h6010, 1'b0);
		probe_prg(16'h8010, 1'b0);
		probe_prg(16'hA010, 1'b0);
		probe_prg(16'hC010, 1'b0);
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog: tests still running after %0d ns", TIMEOUT_NS);
		$display("Something failed");
		$finish;
	end

	initial begin
		void'($urandom(66));
		clk       = 1'b0;
		arst_n    = 1'b0;
		ce        = 1'b1; // every edge is a CPU cycle
		prg_ain   = 16'h0000;
		prg_write = 1'b0;
		prg_din   = 8'h00;
		chr_ain   = 14'h0000;
		for (int i = 0; i < 8; i++) chr_model[i] = 8'h00;
		for (int i = 0; i < 4; i++) prg_model[i] = 5'h00;
		ram_en_model  = 1'b0;
		ram_sel_model = 1'b0;
		mir_model     = 2'd0;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;

		test_reset();
		test_chr();
		test_prg();
		test_mirror();
		test_irq();
		test_ignored();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
verilog/fme7_pkg.sv
verilog/fme7_bank_if.sv
verilog/fme7_irq_if.sv
verilog/fme7_cmd_regs.sv
verilog/fme7_prg_map.sv
verilog/fme7_chr_map.sv
verilog/fme7_irq_counter.sv
verilog/fme7_top.sv
tb/tb_fme7.sv

// File: Makefile
# Verilator build and run for the FME-7 mapper testbench

VERILATOR  ?= verilator
TB_TOP     ?= tb_fme7
RTL_TOP    ?= fme7_top
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= Everything OK

SIM_BIN = $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the run passes only when the pass message shows up in the output
run: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
